// File: hdl/fcvt_defines.svh
// --------------------------------------
// binary32 <-> int32 converter constants
// widths are fixed, nothing here is meant to be overridden
// --------------------------------------
`ifndef FCVT_DEFINES_SVH
`define FCVT_DEFINES_SVH

`define FCVT_WIDTH     32   // operand and result
`define FCVT_EXP_BITS  8
`define FCVT_MAN_BITS  23
`define FCVT_BIAS      127
`define FCVT_MANT_W    32   // internal mantissa holds a whole integer
`define FCVT_EXP_W     10   // signed internal exponent
`define FCVT_SHIFT_W   5    // leading-zero count

// status flag positions, RISC-V fflags order
`define FCVT_FLAG_NV   4
`define FCVT_FLAG_DZ   3
`define FCVT_FLAG_OF   2
`define FCVT_FLAG_UF   1
`define FCVT_FLAG_NX   0

// rounding mode codes
`define FCVT_RM_RNE    3'd0
`define FCVT_RM_RTZ    3'd1
`define FCVT_RM_RDN    3'd2
`define FCVT_RM_RUP    3'd3
`define FCVT_RM_RMM    3'd4

`endif

// File: hdl/fcvt_pkg.sv
// --------------------------------------
// shared types of the converter
// status_t is indexed by the FCVT_FLAG_* positions
// --------------------------------------
`include "fcvt_defines.svh"

package fcvt_pkg;

  typedef logic [`FCVT_WIDTH-1:0]         word_t;
  typedef logic [`FCVT_MANT_W-1:0]        mant_t;
  typedef logic signed [`FCVT_EXP_W-1:0]  exp_t;
  typedef logic [`FCVT_FLAG_NV:0]         status_t;  // NV DZ OF UF NX
  typedef logic [1:0]                     rs_t;      // round, sticky

  typedef enum logic [2:0] {
    RNE = `FCVT_RM_RNE,  // nearest, ties to even
    RTZ = `FCVT_RM_RTZ,
    RDN = `FCVT_RM_RDN,
    RUP = `FCVT_RM_RUP,
    RMM = `FCVT_RM_RMM   // nearest, ties away from zero
  } roundmode_e;

  typedef enum logic {
    F2I = 1'b0,
    I2F = 1'b1
  } operation_e;

endpackage

// File: hdl/fcvt_normalize.sv
// --------------------------------------
// stage 1: classify and normalise operand
// unbiased exponent is relative to a left-justified mantissa
// float classes are only raised for F2I
// --------------------------------------
`timescale 1ns/1ns
`include "fcvt_defines.svh"

module fcvt_normalize (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  fcvt_pkg::word_t      operand_i,
  input  fcvt_pkg::operation_e op_i,
  input  logic                 unsigned_i,
  input  fcvt_pkg::roundmode_e rnd_mode_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output logic                 n_valid_o,
  input  logic                 n_ready_i,
  output logic                 n_sign_o,
  output fcvt_pkg::exp_t       n_exp_o,
  output fcvt_pkg::mant_t      n_mant_o,
  output logic                 n_zero_o,
  output logic                 n_is_nan_o,
  output logic                 n_is_inf_o,
  output logic                 n_is_snan_o,
  output fcvt_pkg::operation_e n_op_o,
  output logic                 n_unsigned_o,
  output fcvt_pkg::roundmode_e n_rnd_o
);
  import fcvt_pkg::*;

  typedef logic [`FCVT_SHIFT_W-1:0] shamt_t;

  logic [`FCVT_EXP_BITS-1:0] exp_field;
  logic [`FCVT_MAN_BITS-1:0] frac_field;
  logic   is_float, is_normal, exp_max;
  logic   int_sign, sign_d;
  logic   is_nan_d, is_inf_d, is_snan_d;
  word_t  int_mag;
  mant_t  enc_mant, norm_mant;
  shamt_t lz_cnt;
  exp_t   exp_d;

  // --------------------------------------
  // operand decode
  // --------------------------------------
  assign is_float   = (op_i == F2I);
  assign exp_field  = operand_i[`FCVT_WIDTH-2 -: `FCVT_EXP_BITS];
  assign frac_field = operand_i[`FCVT_MAN_BITS-1:0];
  assign is_normal  = |exp_field;
  assign exp_max    = &exp_field;

  assign is_nan_d  = is_float & exp_max & (|frac_field);
  assign is_inf_d  = is_float & exp_max & ~(|frac_field);
  assign is_snan_d = is_nan_d & ~frac_field[`FCVT_MAN_BITS-1];  // quiet bit clear

  assign int_sign = operand_i[`FCVT_WIDTH-1] & ~unsigned_i;  // only signed ints go negative
  assign int_mag  = int_sign ? -operand_i : operand_i;
  assign sign_d   = is_float ? operand_i[`FCVT_WIDTH-1] : int_sign;

  // hidden bit in front of the fraction, subnormals keep a 0 there
  assign enc_mant = is_float ? mant_t'({is_normal, frac_field}) : int_mag;

  // --------------------------------------
  // renormalisation
  // --------------------------------------
  always_comb begin : lead_zero_count
    lz_cnt = '0;
    for (int i = 0; i < `FCVT_MANT_W; i++) begin
      if (enc_mant[i]) lz_cnt = shamt_t'(`FCVT_MANT_W - 1 - i);  // highest set bit wins
    end
  end

  assign norm_mant = enc_mant << lz_cnt;

  always_comb begin : unbias_exp
    if (is_float) begin
      // subnormals use exponent 1, and the 8 pad bits are undone by the shift
      exp_d = exp_t'(exp_field) + exp_t'(!is_normal) - exp_t'(`FCVT_BIAS)
              - exp_t'(lz_cnt) + exp_t'(`FCVT_MANT_W - 1 - `FCVT_MAN_BITS);
    end else begin
      exp_d = exp_t'(`FCVT_MANT_W - 1) - exp_t'(lz_cnt);
    end
  end

  // --------------------------------------
  // stage register
  // --------------------------------------
  assign in_ready_o = ~n_valid_o | n_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      n_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      n_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      n_sign_o     <= sign_d;
      n_exp_o      <= exp_d;
      n_mant_o     <= norm_mant;
      n_zero_o     <= ~(|enc_mant);
      n_is_nan_o   <= is_nan_d;
      n_is_inf_o   <= is_inf_d;
      n_is_snan_o  <= is_snan_d;
      n_op_o       <= op_i;
      n_unsigned_o <= unsigned_i;
      n_rnd_o      <= rnd_mode_i;
    end
  end

  // nonzero items leave with the leading one at the top
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    n_valid_o && !n_zero_o |-> n_mant_o[`FCVT_MANT_W-1])
    else $error("normalize: mantissa not left-justified");

endmodule

// File: hdl/fcvt_align.sv
// --------------------------------------
// stage 2: range check and alignment
// one right shifter serves both directions
// a_exp carries the biased float exponent
// --------------------------------------
`timescale 1ns/1ns
`include "fcvt_defines.svh"

module fcvt_align (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 n_valid_i,
  output logic                 n_ready_o,
  input  logic                 n_sign_i,
  input  fcvt_pkg::exp_t       n_exp_i,
  input  fcvt_pkg::mant_t      n_mant_i,
  input  logic                 n_zero_i,
  input  logic                 n_is_nan_i,
  input  logic                 n_is_inf_i,
  input  logic                 n_is_snan_i,
  input  fcvt_pkg::operation_e n_op_i,
  input  logic                 n_unsigned_i,
  input  fcvt_pkg::roundmode_e n_rnd_i,
  output logic                 a_valid_o,
  input  logic                 a_ready_i,
  output logic                 a_sign_o,
  output fcvt_pkg::exp_t       a_exp_o,
  output fcvt_pkg::mant_t      a_mant_o,
  output fcvt_pkg::rs_t        a_rs_o,
  output logic                 a_of_o,
  output logic                 a_zero_o,
  output logic                 a_is_nan_o,
  output logic                 a_is_inf_o,
  output logic                 a_is_snan_o,
  output fcvt_pkg::operation_e a_op_o,
  output logic                 a_unsigned_o,
  output fcvt_pkg::roundmode_e a_rnd_o
);
  import fcvt_pkg::*;

  typedef logic [`FCVT_SHIFT_W:0]     shamt_t;  // up to 33
  typedef logic [2*`FCVT_MANT_W:0]    wide_t;   // mantissa, round slot, sticky field

  shamt_t shamt;
  wide_t  preshift, shifted;
  logic   of_d;
  mant_t  mant_d;
  rs_t    rs_d;

  // --------------------------------------
  // shift amount and integer range
  // --------------------------------------
  always_comb begin : cast_shift
    of_d  = 1'b0;
    shamt = shamt_t'(`FCVT_MANT_W - 1 - `FCVT_MAN_BITS);  // I2F keeps 23 fraction bits
    if (n_op_i == F2I) begin
      if (n_exp_i >= exp_t'(`FCVT_WIDTH - 1) + exp_t'(n_unsigned_i)) begin
        shamt = '0;  // unsigned range is one bit wider
        of_d  = 1'b1;
      end else if (n_exp_i < -exp_t'(1)) begin
        shamt = shamt_t'(`FCVT_MANT_W + 1);  // all bits into sticky
      end else begin
        shamt = shamt_t'(exp_t'(`FCVT_MANT_W - 1) - n_exp_i);
      end
    end
  end

  assign preshift = {n_mant_i, {(`FCVT_MANT_W + 1){1'b0}}};
  assign shifted  = preshift >> shamt;

  // integer sits at the top, fraction lies just below the hidden bit
  assign mant_d = (n_op_i == F2I) ? shifted[`FCVT_MANT_W+1 +: `FCVT_MANT_W]
                                  : mant_t'(shifted[`FCVT_MANT_W+1 +: `FCVT_MAN_BITS]);
  assign rs_d   = {shifted[`FCVT_MANT_W], |shifted[`FCVT_MANT_W-1:0]};

  // --------------------------------------
  // stage register
  // --------------------------------------
  assign n_ready_o = ~a_valid_o | a_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_valid_o <= 1'b0;
    end else if (n_ready_o) begin
      a_valid_o <= n_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (n_valid_i && n_ready_o) begin
      a_sign_o     <= n_sign_i;
      a_exp_o      <= n_exp_i + exp_t'(`FCVT_BIAS);
      a_mant_o     <= mant_d;
      a_rs_o       <= rs_d;
      a_of_o       <= of_d;
      a_zero_o     <= n_zero_i;
      a_is_nan_o   <= n_is_nan_i;
      a_is_inf_o   <= n_is_inf_i;
      a_is_snan_o  <= n_is_snan_i;
      a_op_o       <= n_op_i;
      a_unsigned_o <= n_unsigned_i;
      a_rnd_o      <= n_rnd_i;
    end
  end

  // int32 always fits binary32
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    a_valid_o && (a_op_o == I2F) |-> !a_of_o)
    else $error("align: integer overflow raised on I2F");

endmodule

// File: hdl/fcvt_round.sv
// --------------------------------------
// stage 3: round, pack, special results
// float carry-out of the fraction lands in the exponent
// integer specials saturate and raise NV only
// --------------------------------------
`timescale 1ns/1ns
`include "fcvt_defines.svh"

module fcvt_round (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 a_valid_i,
  output logic                 a_ready_o,
  input  logic                 a_sign_i,
  input  fcvt_pkg::exp_t       a_exp_i,
  input  fcvt_pkg::mant_t      a_mant_i,
  input  fcvt_pkg::rs_t        a_rs_i,
  input  logic                 a_of_i,
  input  logic                 a_zero_i,
  input  logic                 a_is_nan_i,
  input  logic                 a_is_inf_i,
  input  logic                 a_is_snan_i,
  input  fcvt_pkg::operation_e a_op_i,
  input  logic                 a_unsigned_i,
  input  fcvt_pkg::roundmode_e a_rnd_i,
  output fcvt_pkg::word_t      result_o,
  output fcvt_pkg::status_t    status_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);
  import fcvt_pkg::*;

  word_t   pre_abs, rounded_abs;
  word_t   int_res, int_special, fp_res, result_d;
  logic    round_up, any_rs, int_is_special;
  status_t status_d;

  // --------------------------------------
  // rounding
  // --------------------------------------
  assign pre_abs = (a_op_i == I2F)
                   ? {1'b0, a_exp_i[`FCVT_EXP_BITS-1:0], a_mant_i[`FCVT_MAN_BITS-1:0]}
                   : a_mant_i;
  assign any_rs  = |a_rs_i;

  always_comb begin : round_decision
    case (a_rnd_i)
      RNE:     round_up = a_rs_i[1] & (a_rs_i[0] | pre_abs[0]);  // tie goes to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = any_rs & a_sign_i;
      RUP:     round_up = any_rs & ~a_sign_i;
      RMM:     round_up = a_rs_i[1];
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_abs + word_t'(round_up);

  // --------------------------------------
  // result forms
  // --------------------------------------
  assign int_res = a_sign_i ? -rounded_abs : rounded_abs;
  assign fp_res  = a_zero_i ? '0 : {a_sign_i, rounded_abs[`FCVT_WIDTH-2:0]};  // int 0 -> +0

  // negative into unsigned is fine only if it rounded to zero
  assign int_is_special = a_is_nan_i | a_is_snan_i | a_is_inf_i | a_of_i |
                          (a_sign_i & a_unsigned_i & (|rounded_abs));

  always_comb begin : int_saturate
    int_special = {a_unsigned_i, {(`FCVT_WIDTH - 1){1'b1}}};  // max of the int range
    if (a_sign_i && !a_is_nan_i) begin
      int_special = ~int_special;  // min, or 0 when unsigned
    end
  end

  always_comb begin : select_result
    status_d = '0;
    result_d = int_res;
    if (a_op_i == I2F) begin
      result_d                = fp_res;
      status_d[`FCVT_FLAG_NX] = any_rs;
    end else if (int_is_special) begin
      result_d                = int_special;
      status_d[`FCVT_FLAG_NV] = 1'b1;
    end else begin
      status_d[`FCVT_FLAG_NX] = any_rs;
    end
    // no division, and no float range issue for these formats
    status_d[`FCVT_FLAG_DZ] = 1'b0;
    status_d[`FCVT_FLAG_OF] = 1'b0;
    status_d[`FCVT_FLAG_UF] = 1'b0;
  end

  // --------------------------------------
  // output register
  // --------------------------------------
  assign a_ready_o = ~out_valid_o | out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (a_ready_o) begin
      out_valid_o <= a_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_valid_i && a_ready_o) begin  // holds while stalled
      result_o <= result_d;
      status_o <= status_d;
    end
  end

  assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_o)
    else $error("round: output valid during reset");

endmodule

// File: hdl/fcvt_top.sv
// --------------------------------------
// binary32 <-> int32 converter, 3 stages
// latency 3 cycles, one result per cycle
// --------------------------------------
`timescale 1ns/1ns

module fcvt_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  fcvt_pkg::word_t      operand_i,
  input  fcvt_pkg::operation_e op_i,
  input  logic                 unsigned_i,  // integer side is unsigned
  input  fcvt_pkg::roundmode_e rnd_mode_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  output fcvt_pkg::word_t      result_o,
  output fcvt_pkg::status_t    status_o,
  output logic                 out_valid_o,
  input  logic                 out_ready_i
);
  import fcvt_pkg::*;

  // normalize -> align
  logic       n_valid, n_ready, n_sign, n_zero;
  logic       n_is_nan, n_is_inf, n_is_snan, n_unsigned;
  exp_t       n_exp;
  mant_t      n_mant;
  operation_e n_op;
  roundmode_e n_rnd;

  // align -> round
  logic       a_valid, a_ready, a_sign, a_of, a_zero;
  logic       a_is_nan, a_is_inf, a_is_snan, a_unsigned;
  exp_t       a_exp;
  mant_t      a_mant;
  rs_t        a_rs;
  operation_e a_op;
  roundmode_e a_rnd;

  fcvt_normalize u_normalize (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .operand_i    (operand_i),
    .op_i         (op_i),
    .unsigned_i   (unsigned_i),
    .rnd_mode_i   (rnd_mode_i),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .n_valid_o    (n_valid),
    .n_ready_i    (n_ready),
    .n_sign_o     (n_sign),
    .n_exp_o      (n_exp),
    .n_mant_o     (n_mant),
    .n_zero_o     (n_zero),
    .n_is_nan_o   (n_is_nan),
    .n_is_inf_o   (n_is_inf),
    .n_is_snan_o  (n_is_snan),
    .n_op_o       (n_op),
    .n_unsigned_o (n_unsigned),
    .n_rnd_o      (n_rnd)
  );

  fcvt_align u_align (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .n_valid_i    (n_valid),
    .n_ready_o    (n_ready),
    .n_sign_i     (n_sign),
    .n_exp_i      (n_exp),
    .n_mant_i     (n_mant),
    .n_zero_i     (n_zero),
    .n_is_nan_i   (n_is_nan),
    .n_is_inf_i   (n_is_inf),
    .n_is_snan_i  (n_is_snan),
    .n_op_i       (n_op),
    .n_unsigned_i (n_unsigned),
    .n_rnd_i      (n_rnd),
    .a_valid_o    (a_valid),
    .a_ready_i    (a_ready),
    .a_sign_o     (a_sign),
    .a_exp_o      (a_exp),
    .a_mant_o     (a_mant),
    .a_rs_o       (a_rs),
    .a_of_o       (a_of),
    .a_zero_o     (a_zero),
    .a_is_nan_o   (a_is_nan),
    .a_is_inf_o   (a_is_inf),
    .a_is_snan_o  (a_is_snan),
    .a_op_o       (a_op),
    .a_unsigned_o (a_unsigned),
    .a_rnd_o      (a_rnd)
  );

  fcvt_round u_round (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .a_valid_i    (a_valid),
    .a_ready_o    (a_ready),
    .a_sign_i     (a_sign),
    .a_exp_i      (a_exp),
    .a_mant_i     (a_mant),
    .a_rs_i       (a_rs),
    .a_of_i       (a_of),
    .a_zero_i     (a_zero),
    .a_is_nan_i   (a_is_nan),
    .a_is_inf_i   (a_is_inf),
    .a_is_snan_i  (a_is_snan),
    .a_op_i       (a_op),
    .a_unsigned_i (a_unsigned),
    .a_rnd_i      (a_rnd),
    .result_o     (result_o),
    .status_o     (status_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

// File: verification/fcvt_tb.sv
// ----------------------------------------
// testbench for the fcvt_top converter
// directed items first with no stalls, then random items with back-pressure
// stops at the first mismatch, budget of 20 cycles per item
// ----------------------------------------
`timescale 1ns/1ns
`include "fcvt_defines.svh"

module fcvt_tb;
  import fcvt_pkg::*;

  localparam int CLK_HALF  = 2;
  localparam int DRIVE_DLY = 1;
  localparam int N_INT     = 8;
  localparam int N_FLT     = 18;
  localparam int N_DIR     = (N_INT + N_FLT) * 10;  // both int kinds, five modes
  localparam int N_RANDOM  = 1500;
  localparam int N_ITEMS   = N_DIR + N_RANDOM;

  logic       clk = 1'b0;
  logic       rst_n;
  word_t      operand;
  operation_e op;
  logic       uns;
  roundmode_e rnd;
  logic       in_valid, in_ready;
  word_t      result;
  status_t    status;
  logic       out_valid, out_ready;

  logic [31:0] lfsr = 32'd57;
  logic [36:0] stim_q[$];  // op, unsigned, mode, operand
  logic [36:0] exp_q[$];   // status, result
  int          acc_q[$];   // accept edge, -1 once stalls are on
  int          edge_cnt = 0;
  int          n_checked = 0;
  logic        stall_en = 1'b0;

  word_t int_vals [N_INT] = '{
    32'h00000000, 32'h00000001, 32'hFFFFFFFF, 32'h80000000,
    32'h7FFFFFFF, 32'h01000001, 32'h01000003, 32'h00FFFFFF  // ties at 2^24
  };
  word_t flt_vals [N_FLT] = '{
    32'h3FC00000, 32'hBFC00000, 32'h40200000, 32'hC0200000,  // +-1.5 +-2.5
    32'h3F000000, 32'hBF000000, 32'h3F400000, 32'h00000001,  // +-0.5 0.75 subnormal
    32'h80000001, 32'h80000000, 32'h7FC00000, 32'h7F800001,  // -sub -0 qnan snan
    32'h7F800000, 32'hFF800000, 32'h4F000000, 32'hCF000000,  // +-inf +-2^31
    32'h4F800000, 32'h4F7FFFFF                                // 2^32 and just below
  };

  fcvt_top dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .operand_i   (operand),
    .op_i        (op),
    .unsigned_i  (uns),
    .rnd_mode_i  (rnd),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .result_o    (result),
    .status_o    (status),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  always #CLK_HALF clk = ~clk;

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr[0];
      lfsr    = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);  // galois step
    end
    return bits;
  endfunction

  // rem is the dropped part, half is one half ulp of the kept part
  function automatic logic round_away(input roundmode_e m, input logic neg, input logic lsb,
                                      input logic [63:0] rem, input logic [63:0] half);
    logic up;
    up = 1'b0;
    if (rem != 0) begin
      case (m)
        RNE:     up = (rem > half) || ((rem == half) && lsb);
        RDN:     up = neg;
        RUP:     up = !neg;
        RMM:     up = (rem >= half);
        default: up = 1'b0;  // RTZ
      endcase
    end
    return up;
  endfunction

  function automatic logic [36:0] ref_convert(input operation_e f_op, input logic f_uns,
                                              input roundmode_e f_rnd, input word_t f_val);
    logic        sgn, too_big;
    logic [63:0] mag, kept, rem, half;
    int          msb, sh, e;
    word_t       res;
    status_t     st;
    st   = '0;
    rem  = '0;
    half = '0;
    if (f_op == I2F) begin
      sgn = f_val[31] & ~f_uns;
      mag = sgn ? {32'd0, ~f_val} + 64'd1 : 64'(f_val);
      msb = 0;
      for (int i = 0; i < 33; i++) begin
        if (mag[i]) msb = i;
      end
      if (msb > 23) begin  // keep 24 significant bits
        sh   = msb - 23;
        kept = mag >> sh;
        rem  = mag - (kept << sh);
        half = 64'd1 << (sh - 1);
      end else begin
        kept = mag << (23 - msb);
      end
      kept = kept + 64'(round_away(f_rnd, sgn, kept[0], rem, half));
      if (kept[24]) begin  // rounded into the next binade
        kept = kept >> 1;
        msb  = msb + 1;
      end
      res = (mag == 0) ? '0 : {sgn, 8'(msb + `FCVT_BIAS), kept[22:0]};
      st[`FCVT_FLAG_NX] = (rem != 0);
    end else begin
      sgn = f_val[31];
      mag = 64'({f_val[30:23] != 0, f_val[22:0]});
      e   = ((f_val[30:23] == 0) ? 1 : int'(f_val[30:23])) - `FCVT_BIAS - `FCVT_MAN_BITS;
      if (e >= 0) begin
        kept = (e > 32) ? '0 : mag << e;
      end else if (e < -40) begin
        kept = '0;
        rem  = 64'(mag != 0);  // nonzero but far below one half
        half = 64'd2;
      end else begin
        kept = mag >> (-e);
        rem  = mag - (kept << (-e));
        half = 64'd1 << (-e - 1);
      end
      // infinity also lands here through its huge exponent
      too_big = (e > 32) || (kept >= (f_uns ? 64'h1_0000_0000 : 64'h8000_0000));
      if (f_val[30:23] == 8'hFF && f_val[22:0] != 0) begin
        res               = f_uns ? 32'hFFFFFFFF : 32'h7FFFFFFF;
        st[`FCVT_FLAG_NV] = 1'b1;
      end else if (too_big) begin
        if (sgn) res = f_uns ? 32'h00000000 : 32'h80000000;
        else     res = f_uns ? 32'hFFFFFFFF : 32'h7FFFFFFF;
        st[`FCVT_FLAG_NV] = 1'b1;
      end else begin
        kept = kept + 64'(round_away(f_rnd, sgn, kept[0], rem, half));
        if (sgn && f_uns && kept != 0) begin  // negative into unsigned
          res               = '0;
          st[`FCVT_FLAG_NV] = 1'b1;
        end else begin
          res               = sgn ? 32'(64'd0 - kept) : kept[31:0];
          st[`FCVT_FLAG_NX] = (rem != 0);
        end
      end
    end
    return {st, res};
  endfunction

  task automatic fail_run(input string reason);
    if (reason != "") $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at %0t ns", $time);
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
    $display("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
    fail_run("");
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : drive
    logic [36:0] item;
    logic        taken;
    int          idx;
    rst_n     = 1'b0;
    operand   = '0;
    op        = F2I;
    uns       = 1'b0;
    rnd       = RNE;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    taken     = 1'b0;
    idx       = 0;

    foreach (int_vals[i]) begin
      for (int u = 0; u < 2; u++) begin
        for (int m = 0; m < 5; m++) begin
          stim_q.push_back({I2F, 1'(u), 3'(m), int_vals[i]});
        end
      end
    end
    foreach (flt_vals[i]) begin
      for (int u = 0; u < 2; u++) begin
        for (int m = 0; m < 5; m++) begin
          stim_q.push_back({F2I, 1'(u), 3'(m), flt_vals[i]});
        end
      end
    end
    for (int k = 0; k < N_RANDOM; k++) begin
      item[36]    = 1'(rand_bits(1));
      item[35]    = 1'(rand_bits(1));
      item[34:32] = 3'(rand_bits(3) % 5);
      item[31:0]  = rand_bits(32);
      if (item[36] == F2I && rand_bits(1) != 0) begin
        item[30:23] = 8'(100 + rand_bits(6));  // exponents around the int32 range
      end
      stim_q.push_back(item);
    end

    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst_n     = 1'b1;
    out_ready = 1'b1;
    @(negedge clk);
    assert (!out_valid) else value_mismatch("out_valid_o", 32'(out_valid), 32'd0);
    assert (in_ready) else value_mismatch("in_ready_o", 32'(in_ready), 32'd1);

    while (idx < N_ITEMS) begin
      @(posedge clk);
      #DRIVE_DLY;
      if (taken) begin
        in_valid = 1'b0;
        taken    = 1'b0;
      end
      if (idx == N_DIR && !stall_en) begin
        // drain so that directed latencies stay clean
        while (exp_q.size() != 0) begin
          @(posedge clk);
        end
        #DRIVE_DLY;
        stall_en = 1'b1;
      end
      out_ready = stall_en ? (rand_bits(2) != 0) : 1'b1;
      if (!in_valid && (!stall_en || rand_bits(2) != 0)) begin  // random gaps
        item     = stim_q[idx];
        op       = operation_e'(item[36]);
        uns      = item[35];
        rnd      = roundmode_e'(item[34:32]);
        operand  = item[31:0];
        in_valid = 1'b1;
      end
      @(negedge clk);
      if (in_valid && in_ready) begin  // transfer on the coming edge
        exp_q.push_back(ref_convert(op, uns, rnd, operand));
        acc_q.push_back(stall_en ? -1 : edge_cnt + 1);
        idx++;
        taken = 1'b1;
      end
    end

    @(posedge clk);
    #DRIVE_DLY;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);  // catch stray outputs
    if (n_checked == N_ITEMS) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_run($sformatf("only %0d of %0d results were checked", n_checked, N_ITEMS));
    end
  end

  // ----------------------------------------
  // scoreboard
  // ----------------------------------------
  always @(negedge clk) begin : compare_outputs
    logic [36:0] expv;
    int          acc;
    if (rst_n && out_valid && out_ready) begin
      assert (exp_q.size() != 0)
        else fail_run("an output transfer arrived with no input pending");
      expv = exp_q.pop_front();
      acc  = acc_q.pop_front();
      assert (result == expv[31:0])
        else value_mismatch("result_o", result, expv[31:0]);
      assert (status == expv[36:32])
        else value_mismatch("status_o", 32'(status), 32'(expv[36:32]));
      if (acc >= 0) begin  // output leaves on the coming edge
        assert (edge_cnt + 1 - acc == 3)
          else value_mismatch("latency", 32'(edge_cnt + 1 - acc), 32'd3);
      end
      n_checked++;
    end
  end

  initial begin : watchdog
    repeat (N_ITEMS * 20) @(posedge clk);
    fail_run("timeout, the DUT stopped delivering results within the cycle budget");
  end

endmodule

// File: verilog.f
+incdir+hdl
hdl/fcvt_pkg.sv
hdl/fcvt_normalize.sv
hdl/fcvt_align.sv
hdl/fcvt_round.sv
hdl/fcvt_top.sv
verification/fcvt_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fcvt testbench with Verilator
# the log is searched for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module fcvt_tb \
  -Mdir obj_dir -o fcvt_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fcvt_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q -x '\*\*\* PASSED \*\*\*' "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
